//--- flist.f
+incdir+verif
hdl/conv_data_pkg.sv
hdl/conv_ctrl_pkg.sv
hdl/conv_window.sv
hdl/conv_coeff_store.sv
hdl/conv_mac.sv
hdl/conv_result.sv
hdl/conv_top.sv
verif/conv_tb.sv

//--- hdl/conv_coeff_store.sv
`timescale 1ns/1ns

module conv_coeff_store
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
#(
    parameter int NUM_FILTERS = 2
) (
    input  logic                                    i_clk,
    input  logic                                    i_coef_wr,
    input  coef_wr_t                                i_coef,
    output coef_t [NUM_FILTERS-1:0][KERNEL_TAPS-1:0] o_weights,
    output coef_t [NUM_FILTERS-1:0]                 o_biases
);

    // Register file, one row of taps and one bias per filter
    coef_t [NUM_FILTERS-1:0][KERNEL_TAPS-1:0] weight_q;
    coef_t [NUM_FILTERS-1:0]                  bias_q;

    ////////////////////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_coef_wr) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                if (i_coef.filter_idx == filt_idx_t'(f)) begin
                    // Slot 25 goes to the bias
                    if (i_coef.slot_idx == slot_idx_t'(BIAS_SLOT)) begin
                        bias_q[f] <= i_coef.value;
                    end
                    // Remaining slots pick one tap
                    for (int t = 0; t < KERNEL_TAPS; t++) begin
                        if (i_coef.slot_idx == slot_idx_t'(t)) begin
                            weight_q[f][t] <= i_coef.value;
                        end
                    end
                end
            end
        end
    end

    assign o_weights = weight_q;
    assign o_biases  = bias_q;

    // Writes must address an existing filter and slot
    a_coef_addr: assert property (@(posedge i_clk)
        i_coef_wr |-> (int'(i_coef.filter_idx) < NUM_FILTERS &&
                       int'(i_coef.slot_idx) <= BIAS_SLOT));

endmodule

//--- hdl/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Kernel geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int KERNEL_SIZE = 5;
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;
    // Slot index one past the last tap selects the bias
    localparam int BIAS_SLOT   = KERNEL_TAPS;

    // Filter and slot addresses on the coefficient port
    typedef logic [3:0] filt_idx_t;
    typedef logic [4:0] slot_idx_t;

    // One coefficient write
    // Slots 0 to 24 are taps in row-major order, slot 25 is the bias
    typedef struct packed {
        filt_idx_t            filter_idx;
        slot_idx_t            slot_idx;
        conv_data_pkg::coef_t value;
    } coef_wr_t;

    // Frame phase of the window builder
    // PRIME while the first four lines fill, SLIDE once windows form
    typedef enum logic {
        PRIME = 1'b0,
        SLIDE = 1'b1
    } frame_phase_t;

endpackage

//--- hdl/conv_data_pkg.sv
package conv_data_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////////////////////

    // Unsigned input pixel
    typedef logic [7:0] pixel_t;

    // Signed weight or bias word
    typedef logic signed [15:0] coef_t;

    // Weight times zero-extended pixel, 16 + 9 bits
    typedef logic signed [24:0] prod_t;

    // Adder tree sum, room for 25 products plus a bias
    typedef logic signed [31:0] sum_t;

    // Saturated filter result
    typedef logic signed [15:0] out_t;

    // 5x5 pixel window
    // Row 0 is the oldest line, column 0 the leftmost pixel
    typedef struct packed {
        pixel_t [0:4][0:4] tap;
    } window_t;

endpackage

//--- hdl/conv_mac.sv
`timescale 1ns/1ns

module conv_mac
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  window_t                  i_win,
    input  logic                     i_win_valid,
    input  coef_t [KERNEL_TAPS-1:0]  i_weights,
    output sum_t                     o_sum,
    output logic                     o_sum_valid
);

    // Node count per tree level, odd leftovers ride along
    localparam int N0 = KERNEL_TAPS;
    localparam int N1 = (N0 + 1) / 2;
    localparam int N2 = (N1 + 1) / 2;
    localparam int N3 = (N2 + 1) / 2;
    localparam int N4 = (N3 + 1) / 2;
    // Multiply stage plus five adder stages
    localparam int DEPTH = 6;

    prod_t            prod_q [N0];
    sum_t             lvl1_q [N1];
    sum_t             lvl2_q [N2];
    sum_t             lvl3_q [N3];
    sum_t             lvl4_q [N4];
    sum_t             sum_q;
    logic [DEPTH-1:0] valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Multiply
    ////////////////////////////////////////////////////////////////////////////

    // Tap order is row-major, matching the coefficient slots
    always_ff @(posedge i_clk) begin
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            for (int c = 0; c < KERNEL_SIZE; c++) begin
                prod_q[r * KERNEL_SIZE + c] <=
                    i_weights[r * KERNEL_SIZE + c] * $signed({1'b0, i_win.tap[r][c]});
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Adder tree, 25 -> 13 -> 7 -> 4 -> 2 -> 1
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < N0 / 2; i++) begin
            lvl1_q[i] <= sum_t'(prod_q[2 * i]) + sum_t'(prod_q[2 * i + 1]);
        end
        if (N0 % 2 == 1) begin
            lvl1_q[N1 - 1] <= sum_t'(prod_q[N0 - 1]);
        end

        for (int i = 0; i < N1 / 2; i++) begin
            lvl2_q[i] <= lvl1_q[2 * i] + lvl1_q[2 * i + 1];
        end
        if (N1 % 2 == 1) begin
            lvl2_q[N2 - 1] <= lvl1_q[N1 - 1];
        end

        for (int i = 0; i < N2 / 2; i++) begin
            lvl3_q[i] <= lvl2_q[2 * i] + lvl2_q[2 * i + 1];
        end
        if (N2 % 2 == 1) begin
            lvl3_q[N3 - 1] <= lvl2_q[N2 - 1];
        end

        for (int i = 0; i < N3 / 2; i++) begin
            lvl4_q[i] <= lvl3_q[2 * i] + lvl3_q[2 * i + 1];
        end
        if (N3 % 2 == 1) begin
            lvl4_q[N4 - 1] <= lvl3_q[N3 - 1];
        end

        // Final pair
        sum_q <= lvl4_q[0] + lvl4_q[1];
    end

    // Valid bit travels with the data
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[DEPTH-2:0], i_win_valid};
        end
    end

    assign o_sum       = sum_q;
    assign o_sum_valid = valid_q[DEPTH-1];

endmodule

//--- hdl/conv_result.sv
`timescale 1ns/1ns

module conv_result
    import conv_data_pkg::*;
#(
    parameter int NUM_FILTERS = 2
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  sum_t  [NUM_FILTERS-1:0] i_sums,
    input  logic                    i_sums_valid,
    input  coef_t [NUM_FILTERS-1:0] i_biases,
    output logic                    o_valid,
    output out_t  [NUM_FILTERS-1:0] o_result
);

    // Clamp limits of a signed 16-bit result
    localparam sum_t SAT_HI = 32767;
    localparam sum_t SAT_LO = -32768;

    sum_t                   total [NUM_FILTERS];
    out_t                   clamp [NUM_FILTERS];
    out_t [NUM_FILTERS-1:0] result_q;
    logic                   valid_q;

    // Bias add, then clamp to 16 bits
    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            total[f] = i_sums[f] + sum_t'(i_biases[f]);
            if (total[f] > SAT_HI) begin
                clamp[f] = out_t'(SAT_HI);
            end else if (total[f] < SAT_LO) begin
                clamp[f] = out_t'(SAT_LO);
            end else begin
                clamp[f] = out_t'(total[f]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            result_q[f] <= clamp[f];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_sums_valid;
        end
    end

    assign o_valid  = valid_q;
    assign o_result = result_q;

    // Valid chain from the MAC is always known once out of reset
    a_valid_known: assert property (@(posedge i_clk) disable iff (i_rst)
        !$isunknown(i_sums_valid));

endmodule

//--- hdl/conv_top.sv
`timescale 1ns/1ns

module conv_top
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
#(
    parameter int IMG_W       = 12,
    parameter int IMG_H       = 10,
    parameter int NUM_FILTERS = 2
) (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_pix_valid,
    input  pixel_t                 i_pix,
    input  logic                   i_coef_wr,
    input  coef_wr_t               i_coef,
    output logic                   o_valid,
    output out_t [NUM_FILTERS-1:0] o_result
);

    window_t                                  win;
    logic                                     win_valid;
    coef_t [NUM_FILTERS-1:0][KERNEL_TAPS-1:0] weights;
    coef_t [NUM_FILTERS-1:0]                  biases;
    sum_t  [NUM_FILTERS-1:0]                  sums;
    // All filters run in lockstep, so every bit carries the same value
    logic  [NUM_FILTERS-1:0]                  sums_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Decode: line buffers and window
    ////////////////////////////////////////////////////////////////////////////

    conv_window #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_window (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_win       (win),
        .o_win_valid (win_valid)
    );

    conv_coeff_store #(
        .NUM_FILTERS (NUM_FILTERS)
    ) u_coeff_store (
        .i_clk     (i_clk),
        .i_coef_wr (i_coef_wr),
        .i_coef    (i_coef),
        .o_weights (weights),
        .o_biases  (biases)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute: one MAC pipeline per filter
    ////////////////////////////////////////////////////////////////////////////

    for (genvar f = 0; f < NUM_FILTERS; f++) begin : g_filter
        conv_mac u_mac (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_win       (win),
            .i_win_valid (win_valid),
            .i_weights   (weights[f]),
            .o_sum       (sums[f]),
            .o_sum_valid (sums_valid[f])
        );
    end

    // Result: bias, saturate, output strobe
    conv_result #(
        .NUM_FILTERS (NUM_FILTERS)
    ) u_result (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_sums       (sums),
        .i_sums_valid (sums_valid[0]),
        .i_biases     (biases),
        .o_valid      (o_valid),
        .o_result     (o_result)
    );

endmodule

//--- hdl/conv_window.sv
`timescale 1ns/1ns

module conv_window
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
#(
    parameter int IMG_W = 12,
    parameter int IMG_H = 10
) (
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_pix_valid,
    input  pixel_t  i_pix,
    output window_t o_win,
    output logic    o_win_valid
);

    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);
    // One stored line per window row except the newest
    localparam int LINES = KERNEL_SIZE - 1;

    // Line buffers, line 0 holds the oldest row
    pixel_t           line_mem [LINES][IMG_W];
    // Column entering the window: stored lines plus the new pixel
    pixel_t           new_col  [KERNEL_SIZE];

    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             last_col;
    logic             last_row;
    frame_phase_t     phase_q;
    frame_phase_t     phase_d;

    window_t          win_q;
    logic             win_valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Frame position
    ////////////////////////////////////////////////////////////////////////////

    assign last_col = (col_q == COL_W'(IMG_W - 1));
    assign last_row = (row_q == ROW_W'(IMG_H - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col_q   <= '0;
            row_q   <= '0;
            phase_q <= PRIME;
        end else if (i_pix_valid) begin
            phase_q <= phase_d;
            if (last_col) begin
                col_q <= '0;
                // Wrap at frame end, next pixel starts a new frame
                row_q <= last_row ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // Phase FSM, only advances on the last pixel of a row
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PRIME: begin
                // Row 3 done, four lines now buffered
                if (last_col && row_q == ROW_W'(KERNEL_SIZE - 2)) begin
                    phase_d = SLIDE;
                end
            end
            SLIDE: begin
                if (last_col && last_row) begin
                    phase_d = PRIME;
                end
            end
            default: phase_d = PRIME;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Line buffers and window
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int r = 0; r < LINES; r++) begin
            new_col[r] = line_mem[r][col_q];
        end
        new_col[LINES] = i_pix;
    end

    always_ff @(posedge i_clk) begin
        if (i_pix_valid) begin
            // Column moves up one line on write-back, oldest pixel drops out
            for (int r = 0; r < LINES; r++) begin
                line_mem[r][col_q] <= new_col[r + 1];
            end
            // Shift left, new column enters at the right
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                for (int c = 0; c < KERNEL_SIZE - 1; c++) begin
                    win_q.tap[r][c] <= win_q.tap[r][c + 1];
                end
                win_q.tap[r][KERNEL_SIZE - 1] <= new_col[r];
            end
        end
    end

    // Window complete once five columns of a SLIDE row are in
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            win_valid_q <= 1'b0;
        end else begin
            win_valid_q <= i_pix_valid && (phase_q == SLIDE) &&
                           (col_q >= COL_W'(KERNEL_SIZE - 1));
        end
    end

    assign o_win       = win_q;
    assign o_win_valid = win_valid_q;

    // Column counter wraps before it reaches the line length
    a_col_range: assert property (@(posedge i_clk) disable iff (i_rst)
        int'(col_q) < IMG_W);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the convolution engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module conv_tb \
    --Mdir obj_dir -o conv_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/conv_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- verif/conv_tb_model.svh
`ifndef CONV_TB_MODEL_SVH
`define CONV_TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model of one output
////////////////////////////////////////////////////////////////////////////

// Pixels of the current frame, row-major, overwritten as the next frame arrives
pixel_t frame_mem [IMG_H][IMG_W];

// Mirror of the DUT coefficients, updated with every write
int     weight_mdl [NUM_FILTERS][KERNEL_TAPS];
int     bias_mdl   [NUM_FILTERS];

function automatic void store_pixel(int row, int col, pixel_t pix);
    frame_mem[row][col] = pix;
endfunction

function automatic void store_coef(int filt, int slot, int value);
    if (slot == BIAS_SLOT) begin
        bias_mdl[filt] = value;
    end else begin
        weight_mdl[filt][slot] = value;
    end
endfunction

// Window with its bottom-right pixel at (row, col)
function automatic int ref_output(int filt, int row, int col);
    int acc;
    int top;
    int left;
    acc  = bias_mdl[filt];
    top  = row - (KERNEL_SIZE - 1);
    left = col - (KERNEL_SIZE - 1);
    // Taps in row-major order, pixels zero-extended
    for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
        for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
            acc += weight_mdl[filt][kr * KERNEL_SIZE + kc] *
                   int'(frame_mem[top + kr][left + kc]);
        end
    end
    // Clamp to signed 16 bits
    if (acc > 32767) begin
        acc = 32767;
    end else if (acc < -32768) begin
        acc = -32768;
    end
    return acc;
endfunction

`endif

//--- verif/conv_tb.sv
`timescale 1ns/1ns

module conv_tb
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
();

    localparam int IMG_W          = 12;
    localparam int IMG_H          = 10;
    localparam int NUM_FILTERS    = 2;
    // Pixel accepted to o_valid
    localparam int PIPE_LATENCY   = 8;
    localparam int FRAME_PIXELS   = IMG_W * IMG_H;
    localparam int WIN_PER_FRAME  = (IMG_W - 4) * (IMG_H - 4);
    // Frames streamed over all tests
    localparam int TOTAL_FRAMES   = 6;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_FRAMES * FRAME_PIXELS + 200;

    // Pixel sources
    localparam int PIX_RAMP  = 0;
    localparam int PIX_RAND  = 1;
    localparam int PIX_FULL  = 2;
    // Coefficient sets
    localparam int COEF_ONES = 0;
    localparam int COEF_RAND = 1;
    localparam int COEF_SAT  = 2;

    // One pending window, cycle of its completing pixel plus all filter values
    typedef struct packed {
        int                     cycle;
        out_t [NUM_FILTERS-1:0] value;
    } expect_t;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_pix_valid;
    pixel_t                 i_pix;
    logic                   i_coef_wr;
    coef_wr_t               i_coef;
    logic                   o_valid;
    out_t [NUM_FILTERS-1:0] o_result;

    int      seed = 76;
    int      cycle_cnt = 0;
    int      err_cnt = 0;
    int      check_cnt = 0;
    int      result_cnt = 0;
    int      clamp_hits = 0;
    int      test_cnt = 0;
    int      test_err_start = 0;
    int      test_res_start = 0;
    int      clamp_start = 0;
    // Raster position of the next pixel, tracked from the frame rules
    int      pix_row = 0;
    int      pix_col = 0;
    expect_t exp_q [$];

    `include "conv_tb_model.svh"

    conv_top u_dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .i_coef_wr   (i_coef_wr),
        .i_coef      (i_coef),
        .o_valid     (o_valid),
        .o_result    (o_result)
    );

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("ERROR at %0t: run did not finish within %0d cycles", $time, TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(string name, int got, int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Store the pixel, queue a result if it completes a window
    function automatic void record_pixel();
        expect_t e;
        store_pixel(pix_row, pix_col, i_pix);
        if (pix_row >= KERNEL_SIZE - 1 && pix_col >= KERNEL_SIZE - 1) begin
            e.cycle = cycle_cnt;
            for (int f = 0; f < NUM_FILTERS; f++) begin
                e.value[f] = out_t'(ref_output(f, pix_row, pix_col));
            end
            exp_q.push_back(e);
        end
        if (pix_col == IMG_W - 1) begin
            pix_col = 0;
            pix_row = (pix_row == IMG_H - 1) ? 0 : pix_row + 1;
        end else begin
            pix_col++;
        end
    endfunction

    task automatic compare_output();
        expect_t e;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("ERROR at %0t: o_valid pulsed with no window pending", $time);
        end else begin
            e = exp_q.pop_front();
            result_cnt++;
            check_value("latency", cycle_cnt - e.cycle, PIPE_LATENCY);
            for (int f = 0; f < NUM_FILTERS; f++) begin
                check_value($sformatf("o_result[%0d]", f), int'(o_result[f]), int'(e.value[f]));
            end
            if (int'(o_result[0]) == 32767 && int'(o_result[1]) == -32768) begin
                clamp_hits++;
            end
        end
    endtask

    // Midway between edges, inputs and outputs are both settled
    always @(negedge i_clk) begin
        if (i_rst) begin
            pix_row = 0;
            pix_col = 0;
            if (o_valid !== 1'b0) begin
                err_cnt++;
                $display("ERROR at %0t: o_valid not low during reset", $time);
            end
        end else begin
            if (i_pix_valid) begin
                record_pixel();
            end
            if ($isunknown(o_valid)) begin
                err_cnt++;
                $display("ERROR at %0t: o_valid is unknown", $time);
            end else if (o_valid) begin
                compare_output();
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_pixel(pixel_t pix);
        @(posedge i_clk);
        #1;
        i_pix_valid = 1'b1;
        i_pix       = pix;
    endtask

    task automatic drive_idle();
        @(posedge i_clk);
        #1;
        i_pix_valid = 1'b0;
    endtask

    task automatic write_coef(int filt, int slot, int value);
        @(posedge i_clk);
        #1;
        i_coef_wr         = 1'b1;
        i_coef.filter_idx = filt_idx_t'(filt);
        i_coef.slot_idx   = slot_idx_t'(slot);
        i_coef.value      = coef_t'(value);
        store_coef(filt, slot, value);
    endtask

    // Only called with the pipeline empty
    task automatic load_coefs(int mode);
        int value;
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int s = 0; s <= BIAS_SLOT; s++) begin
                case (mode)
                    COEF_ONES: value = (s == BIAS_SLOT) ? 0 : 1;
                    // Even filters push up, odd filters push down
                    COEF_SAT:  value = (f % 2 == 0) ? 32767 : -32768;
                    default:   value = (s == BIAS_SLOT) ? $random(seed) % 2048 :
                                                          $random(seed) % 64;
                endcase
                write_coef(f, s, value);
            end
        end
        @(posedge i_clk);
        #1;
        i_coef_wr = 1'b0;
    endtask

    function automatic pixel_t make_pixel(int kind, int row, int col);
        case (kind)
            PIX_RAMP: return pixel_t'(row * IMG_W + col);
            PIX_FULL: return 8'hff;
            default:  return pixel_t'($random(seed));
        endcase
    endfunction

    task automatic send_frame(int kind, bit gaps);
        int gap;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                drive_pixel(make_pixel(kind, r, c));
                if (gaps) begin
                    gap = {$random(seed)} % 3;
                    repeat (gap) drive_idle();
                end
            end
        end
    endtask

    // Wait until every queued window has come out, then a few spare cycles
    task automatic drain();
        drive_idle();
        while (exp_q.size() != 0) begin
            @(posedge i_clk);
        end
        repeat (4) @(posedge i_clk);
    endtask

    task automatic begin_test();
        test_err_start = err_cnt;
        test_res_start = result_cnt;
    endtask

    task automatic end_test(string name, int exp_results);
        check_value("result count", result_cnt - test_res_start, exp_results);
        test_cnt++;
        $display("test %0d %-14s %0d results, %0d errors", test_cnt, name,
                 result_cnt - test_res_start, err_cnt - test_err_start);
    endtask

    initial begin
        i_clk       = 1'b0;
        i_rst       = 1'b1;
        i_pix_valid = 1'b0;
        i_pix       = '0;
        i_coef_wr   = 1'b0;
        i_coef      = '0;

        // Reset for two cycles, nothing may come out
        begin_test();
        repeat (2) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        repeat (4) drive_idle();
        check_value("o_valid", int'(o_valid), 0);
        end_test("reset", 0);

        // All-ones kernel over a ramp, result is the window sum
        begin_test();
        load_coefs(COEF_ONES);
        send_frame(PIX_RAMP, 1'b0);
        drain();
        end_test("simple kernel", WIN_PER_FRAME);

        begin_test();
        load_coefs(COEF_RAND);
        send_frame(PIX_RAND, 1'b1);
        drain();
        end_test("random gaps", WIN_PER_FRAME);

        // Second frame starts right after the first
        begin_test();
        send_frame(PIX_RAND, 1'b0);
        send_frame(PIX_RAMP, 1'b0);
        drain();
        end_test("back to back", 2 * WIN_PER_FRAME);

        begin_test();
        load_coefs(COEF_SAT);
        clamp_start = clamp_hits;
        send_frame(PIX_FULL, 1'b0);
        drain();
        check_value("clamped results", clamp_hits - clamp_start, WIN_PER_FRAME);
        end_test("saturation", WIN_PER_FRAME);

        begin_test();
        load_coefs(COEF_RAND);
        send_frame(PIX_RAND, 1'b0);
        drain();
        end_test("coef reload", WIN_PER_FRAME);

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
